/* logic/usbCrcCheck.sv */
/* Serial CRC register with residue compare.
   Preset on init, advanced one bit per shift, match while residue holds. */

module usbCrcCheck #(
	parameter int width = 5,
	parameter logic [width-1:0] poly = 5'b00101,
	parameter logic [width-1:0] residue = 5'b01100
) (
	input logic clk,
	input logic rst_L,
	input logic init,
	input logic shift,
	input logic inBit,
	output logic match
);

	logic [width-1:0] crc;
	logic feedback;

	// MSB out xor incoming bit
	assign feedback = crc[width-1] ^ inBit;

	always_ff @(posedge clk, negedge rst_L) begin
		if (!rst_L)
			crc <= '1;
		else if (init)
			crc <= '1;
		else if (shift)
			crc <= {crc[width-2:0], 1'b0} ^ ({width{feedback}} & poly);
	end

	// Complemented CRC shifted in leaves a fixed residue
	assign match = (crc == residue);

endmodule

/* logic/usbHandshakeTx.sv */
/* Handshake sender: SYNC, PID and EOP, NRZI-encoded onto the output pins.
   Drives from the send cycle for handshakeBits cycles, done on the last. */

module usbHandshakeTx (
	input logic clk,
	input logic rst_L,
	input logic send,
	input logic [usbPkg::pidBits-1:0] sendPid,
	output logic dpOut,
	output logic dmOut,
	output logic lineDrive,
	output logic done
);

	logic active;
	logic [4:0] phase, curPhase;
	logic [usbPkg::pidBits-1:0] txShift;
	logic lineJ, nextJ, nrzBit;
	logic inSync, inPid, lastPhase;

	//********************************************************************
	// Phase decode
	//********************************************************************
	// Send cycle is phase zero
	assign curPhase = send ? 5'd0 : phase;
	assign inSync = curPhase < usbPkg::syncBits;
	assign inPid = !inSync && (curPhase < usbPkg::syncBits + usbPkg::pidBits);
	assign lastPhase = curPhase == usbPkg::handshakeBits - 1;

	assign lineDrive = send | active;
	assign done = active && lastPhase;

	// SYNC is seven zeros and a one, PID goes MSB first
	assign nrzBit = inSync ? (curPhase == usbPkg::syncBits - 1) :
		txShift[usbPkg::pidBits-1];
	assign nextJ = nrzBit ? lineJ : ~lineJ;

	//********************************************************************
	// NRZI encoder and pin drive
	//********************************************************************
	always_comb begin
		if (!lineDrive || lastPhase)
			{dpOut, dmOut} = 2'b10;	// J
		else if (inSync || inPid)
			{dpOut, dmOut} = nextJ ? 2'b10 : 2'b01;
		else
			{dpOut, dmOut} = 2'b00;	// SE0 of EOP
	end

	always_ff @(posedge clk, negedge rst_L) begin
		if (!rst_L) begin
			active <= 1'b0;
			phase <= 5'd0;
			lineJ <= 1'b1;
		end
		else begin
			if (send) begin
				active <= 1'b1;
				phase <= 5'd1;
			end
			else if (active) begin
				if (lastPhase) begin
					active <= 1'b0;
					phase <= 5'd0;
				end
				else
					phase <= phase + 1'b1;
			end
			// Line idles J again after EOP
			if (lineDrive)
				lineJ <= (inSync || inPid) ? nextJ : 1'b1;
		end
	end

	// PID held for the whole packet, shifted during its own phases
	always_ff @(posedge clk) begin
		if (send)
			txShift <= sendPid;
		else if (active && inPid)
			txShift <= {txShift[usbPkg::pidBits-2:0], 1'b0};
	end

endmodule

/* logic/usbIfs.sv */
/* Internal buses of the USB OUT device.
   usbLineIf joins the line receiver to the packet receiver,
   usbPacketIf joins the packet receiver to the transaction FSM. */

//**********************************************************************
// Bit level, line receiver to packet receiver
//**********************************************************************
interface usbLineIf;
	// Decoded NRZ bit of the current sample
	logic rxBit;
	// Current bit is a stuffed zero
	logic stuffed;
	// Single-cycle pulses on the sampled state
	logic sop;
	logic eop;
	logic eopMiss;
	// Requests back from the packet receiver
	logic unstuffEn;
	logic lookEop;

	modport rx (output rxBit, stuffed, sop, eop, eopMiss, input unstuffEn, lookEop);
	modport pkt (input rxBit, stuffed, sop, eop, eopMiss, output unstuffEn, lookEop);
endinterface

//**********************************************************************
// Packet level, packet receiver to transaction FSM
//**********************************************************************
interface usbPacketIf;
	// Pulses in the cycle of the closing J
	logic outToken;
	logic dataPacket;
	// CRC16 result, only meaningful with dataPacket
	logic dataGood;
	// Held until the next SYNC
	logic [usbPkg::payloadBits-1:0] payload;

	modport src (output outToken, dataPacket, dataGood, payload);
	modport sink (input outToken, dataPacket, dataGood, payload);
endinterface

/* logic/usbLineRx.sv */
/* Line receiver: NRZI decode, SYNC search, stuffed-bit flagging and EOP check.
   Samples one bus state per clk, all outputs follow the current sample. */

module usbLineRx (
	input logic clk,
	input logic rst_L,
	input logic dpIn,
	input logic dmIn,
	usbLineIf.rx line
);

	logic lineJ, lineK, lineSe0;
	logic prevJ;
	logic [2:0] syncStep, syncNext;
	logic syncExpectK, syncMatch;
	logic [2:0] onesCount;
	logic [1:0] eopStep, eopNext;

	assign lineJ = dpIn & ~dmIn;
	assign lineK = ~dpIn & dmIn;
	assign lineSe0 = ~dpIn & ~dmIn;

	//********************************************************************
	// NRZI decode
	//********************************************************************
	// No change reads as 1, SE0 reads as 0
	assign line.rxBit = (lineJ & prevJ) | (lineK & ~prevJ);

	always_ff @(posedge clk, negedge rst_L) begin
		if (!rst_L)
			prevJ <= 1'b1;	// idle line is J
		else if (lineJ)
			prevJ <= 1'b1;
		else if (lineK)
			prevJ <= 1'b0;
	end

	//********************************************************************
	// SYNC matcher, KJKJKJKK
	//********************************************************************
	// Even steps and the last step want K
	assign syncExpectK = ~syncStep[0] | (syncStep == usbPkg::syncBits - 1);
	assign syncMatch = syncExpectK ? lineK : lineJ;

	always_comb begin
		syncNext = 3'd0;
		line.sop = 1'b0;
		if (lineSe0)
			syncNext = 3'd0;
		else if (syncStep == usbPkg::syncBits - 1) begin
			if (lineK)
				line.sop = 1'b1;
			// KJKJKJKJ still ends in a valid six-state prefix
			else if (lineJ)
				syncNext = 3'd6;
		end
		else if (syncMatch)
			syncNext = syncStep + 1'b1;
		// K K out of sequence, second K starts over
		else if (lineK)
			syncNext = 3'd1;
	end

	always_ff @(posedge clk, negedge rst_L) begin
		if (!rst_L)
			syncStep <= 3'd0;
		else
			syncStep <= syncNext;
	end

	//********************************************************************
	// Stuffed bit detector
	//********************************************************************
	assign line.stuffed = line.unstuffEn && (onesCount == usbPkg::stuffRun);

	always_ff @(posedge clk, negedge rst_L) begin
		if (!rst_L)
			onesCount <= 3'd0;
		else if (!line.unstuffEn || line.stuffed || !line.rxBit)
			onesCount <= 3'd0;
		else
			onesCount <= onesCount + 1'b1;
	end

	//********************************************************************
	// EOP matcher, SE0 SE0 J
	//********************************************************************
	always_comb begin
		eopNext = 2'd0;
		line.eop = 1'b0;
		line.eopMiss = 1'b0;
		case (eopStep)
			2'd0: begin
				if (line.lookEop) begin
					if (lineSe0)
						eopNext = 2'd1;
					else
						line.eopMiss = 1'b1;
				end
			end
			2'd1: begin
				if (lineSe0)
					eopNext = 2'd2;
				else
					line.eopMiss = 1'b1;
			end
			default: begin
				// Closing J or a broken EOP
				line.eop = lineJ;
				line.eopMiss = ~lineJ;
			end
		endcase
	end

	always_ff @(posedge clk, negedge rst_L) begin
		if (!rst_L)
			eopStep <= 2'd0;
		else
			eopStep <= eopNext;
	end

endmodule

/* logic/usbOutDevice.sv */
/* Full-speed USB device receiving OUT transfers on endpoint 3.
   Split bus pins with a drive enable, accepted payloads on rxPayload. */

module usbOutDevice #(
	parameter logic [usbPkg::addrBits-1:0] deviceAddr = 7'h00
) (
	input logic clk,
	input logic rst_L,
	input logic dpIn,
	input logic dmIn,
	output logic dpOut,
	output logic dmOut,
	output logic lineDrive,
	output logic [usbPkg::payloadBits-1:0] rxPayload,
	output logic rxPayloadValid
);

	// Transaction to sender
	logic send;
	logic [usbPkg::pidBits-1:0] sendPid;
	logic done;

	usbLineIf lineBus ();
	usbPacketIf pktBus ();

	//********************************************************************
	// Receive path
	//********************************************************************
	usbLineRx lineRx0 (
		.clk(clk),
		.rst_L(rst_L),
		.dpIn(dpIn),
		.dmIn(dmIn),
		.line(lineBus)
	);

	usbPacketRx #(.deviceAddr(deviceAddr)) packetRx0 (
		.clk(clk),
		.rst_L(rst_L),
		.line(lineBus),
		.pkt(pktBus)
	);

	//********************************************************************
	// Transaction and handshake
	//********************************************************************
	usbTransaction transaction0 (
		.clk(clk),
		.rst_L(rst_L),
		.pkt(pktBus),
		.done(done),
		.send(send),
		.sendPid(sendPid),
		.rxPayload(rxPayload),
		.rxPayloadValid(rxPayloadValid)
	);

	usbHandshakeTx handshakeTx0 (
		.clk(clk),
		.rst_L(rst_L),
		.send(send),
		.sendPid(sendPid),
		.dpOut(dpOut),
		.dmOut(dmOut),
		.lineDrive(lineDrive),
		.done(done)
	);

endmodule

/* logic/usbPacketRx.sv */
/* Packet receiver: reads PID, OUT token and DATA payload after each SYNC.
   Checks CRC5 and CRC16 and reports each finished packet at its closing J. */

module usbPacketRx #(
	parameter logic [usbPkg::addrBits-1:0] deviceAddr = 7'h00
) (
	input logic clk,
	input logic rst_L,
	usbLineIf.pkt line,
	usbPacketIf.src pkt
);

	logic [usbPkg::rxStateBits-1:0] state, stateNext;
	logic [6:0] bitCount;
	logic inField, takeBit;
	logic [usbPkg::pidBits-1:0] pidReg, pidNow;
	logic isData;
	logic [usbPkg::addrBits+usbPkg::endpBits-1:0] tokenReg;
	logic [usbPkg::payloadBits-1:0] payloadReg;
	logic crcInit, crc5Shift, crc16Shift;
	logic crc5Match, crc16Match;
	logic atEop, tokenHit;

	assign inField = (state == usbPkg::rxPid) || (state == usbPkg::rxToken) ||
		(state == usbPkg::rxData);
	// Stuffed zeros never reach a field
	assign takeBit = inField && !line.stuffed;
	assign pidNow = {pidReg[usbPkg::pidBits-2:0], line.rxBit};

	//********************************************************************
	// Receiver FSM
	//********************************************************************
	always_comb begin
		stateNext = state;
		case (state)
			usbPkg::rxWaitSync:
				if (line.sop)
					stateNext = usbPkg::rxPid;
			usbPkg::rxPid:
				// Classify at the eighth bit
				if (takeBit && bitCount == usbPkg::pidBits - 1) begin
					if (pidNow == usbPkg::pidOut)
						stateNext = usbPkg::rxToken;
					else if (pidNow == usbPkg::pidData)
						stateNext = usbPkg::rxData;
					else
						stateNext = usbPkg::rxWaitSync;
				end
			usbPkg::rxToken:
				if (takeBit && bitCount == usbPkg::tokenBits - 1)
					stateNext = usbPkg::rxEop;
			usbPkg::rxData:
				// Payload then its CRC16
				if (takeBit && bitCount == usbPkg::payloadBits + usbPkg::crc16Bits - 1)
					stateNext = usbPkg::rxEop;
			usbPkg::rxEop:
				if (line.eop || line.eopMiss)
					stateNext = usbPkg::rxWaitSync;
			default:
				stateNext = usbPkg::rxWaitSync;
		endcase
	end

	always_ff @(posedge clk, negedge rst_L) begin
		if (!rst_L) begin
			state <= usbPkg::rxWaitSync;
			bitCount <= 7'd0;
			isData <= 1'b0;
		end
		else begin
			state <= stateNext;
			// Count restarts with every field
			if (state != stateNext)
				bitCount <= 7'd0;
			else if (takeBit)
				bitCount <= bitCount + 1'b1;
			if (state == usbPkg::rxPid && stateNext != usbPkg::rxPid)
				isData <= (pidNow == usbPkg::pidData);
		end
	end

	//********************************************************************
	// Field shift registers
	//********************************************************************
	always_ff @(posedge clk) begin
		if (takeBit && state == usbPkg::rxPid)
			pidReg <= pidNow;
		// Token and payload come LSB first
		if (takeBit && state == usbPkg::rxToken &&
			bitCount < usbPkg::addrBits + usbPkg::endpBits)
			tokenReg <= {line.rxBit, tokenReg[usbPkg::addrBits+usbPkg::endpBits-1:1]};
		if (takeBit && state == usbPkg::rxData && bitCount < usbPkg::payloadBits)
			payloadReg <= {line.rxBit, payloadReg[usbPkg::payloadBits-1:1]};
	end

	//********************************************************************
	// CRC checks
	//********************************************************************
	assign crcInit = (state == usbPkg::rxWaitSync) && line.sop;
	assign crc5Shift = takeBit && (state == usbPkg::rxToken);
	assign crc16Shift = takeBit && (state == usbPkg::rxData);

	usbCrcCheck #(
		.width(usbPkg::crc5Bits),
		.poly(usbPkg::crc5Poly),
		.residue(usbPkg::crc5Residue)
	) crc5Chk (
		.clk(clk),
		.rst_L(rst_L),
		.init(crcInit),
		.shift(crc5Shift),
		.inBit(line.rxBit),
		.match(crc5Match)
	);

	usbCrcCheck #(
		.width(usbPkg::crc16Bits),
		.poly(usbPkg::crc16Poly),
		.residue(usbPkg::crc16Residue)
	) crc16Chk (
		.clk(clk),
		.rst_L(rst_L),
		.init(crcInit),
		.shift(crc16Shift),
		.inBit(line.rxBit),
		.match(crc16Match)
	);

	//********************************************************************
	// Line requests and packet outcome
	//********************************************************************
	// A stuffed bit after the last CRC bit is skipped before EOP
	assign line.unstuffEn = inField || (state == usbPkg::rxEop);
	assign line.lookEop = (state == usbPkg::rxEop) && !line.stuffed;

	assign atEop = (state == usbPkg::rxEop) && line.eop;
	assign tokenHit = (tokenReg[usbPkg::addrBits-1:0] == deviceAddr) &&
		(tokenReg[usbPkg::addrBits+usbPkg::endpBits-1:usbPkg::addrBits] ==
		usbPkg::outEndpoint);

	assign pkt.outToken = atEop && !isData && tokenHit && crc5Match;
	assign pkt.dataPacket = atEop && isData;
	assign pkt.dataGood = crc16Match;
	assign pkt.payload = payloadReg;

endmodule

/* logic/usbPkg.sv */
/* Protocol constants for the full-speed USB OUT device.
   PIDs, field widths, CRC polynomials and residues, and FSM state codes. */

package usbPkg;

	//********************************************************************
	// Packet identifiers, sent MSB first
	//********************************************************************
	localparam int pidBits = 8;
	localparam logic [pidBits-1:0] pidAck = 8'b0100_1011;
	localparam logic [pidBits-1:0] pidNak = 8'b0101_1010;
	localparam logic [pidBits-1:0] pidOut = 8'b1000_0111;
	localparam logic [pidBits-1:0] pidData = 8'b1100_0011;

	// Token is addr, endpoint, then CRC5
	localparam int tokenBits = 16;
	localparam int addrBits = 7;
	localparam int endpBits = 4;
	localparam logic [endpBits-1:0] outEndpoint = 4'd3;
	localparam int payloadBits = 64;

	//********************************************************************
	// CRC generators, registers preset to all ones
	//********************************************************************
	localparam int crc5Bits = 5;
	localparam logic [crc5Bits-1:0] crc5Poly = 5'b00101;
	localparam logic [crc5Bits-1:0] crc5Residue = 5'b01100;
	localparam int crc16Bits = 16;
	localparam logic [crc16Bits-1:0] crc16Poly = 16'h8005;
	localparam logic [crc16Bits-1:0] crc16Residue = 16'h800d;

	// Line framing
	localparam int stuffRun = 6;
	localparam int syncBits = 8;
	localparam int eopBits = 3;
	localparam int handshakeBits = syncBits + pidBits + eopBits;

	// Receiver FSM codes
	localparam int rxStateBits = 3;
	localparam logic [rxStateBits-1:0] rxWaitSync = 3'd0;
	localparam logic [rxStateBits-1:0] rxPid = 3'd1;
	localparam logic [rxStateBits-1:0] rxToken = 3'd2;
	localparam logic [rxStateBits-1:0] rxData = 3'd3;
	localparam logic [rxStateBits-1:0] rxEop = 3'd4;

	// Transaction FSM codes
	localparam int txnStateBits = 2;
	localparam logic [txnStateBits-1:0] txnIdle = 2'd0;
	localparam logic [txnStateBits-1:0] txnAwait = 2'd1;
	localparam logic [txnStateBits-1:0] txnSend = 2'd2;

endpackage

/* logic/usbTransaction.sv */
/* OUT transaction FSM: accepts a DATA packet after a matching OUT token.
   Answers ACK with a payload strobe on good CRC16, NAK otherwise. */

module usbTransaction (
	input logic clk,
	input logic rst_L,
	usbPacketIf.sink pkt,
	input logic done,
	output logic send,
	output logic [usbPkg::pidBits-1:0] sendPid,
	output logic [usbPkg::payloadBits-1:0] rxPayload,
	output logic rxPayloadValid
);

	logic [usbPkg::txnStateBits-1:0] state;
	logic dataSeen;

	// DATA only counts after an accepted OUT
	assign dataSeen = (state == usbPkg::txnAwait) && pkt.dataPacket;

	//********************************************************************
	// Transaction FSM
	//********************************************************************
	always_ff @(posedge clk, negedge rst_L) begin
		if (!rst_L) begin
			state <= usbPkg::txnIdle;
			send <= 1'b0;
			sendPid <= usbPkg::pidNak;
			rxPayloadValid <= 1'b0;
		end
		else begin
			// Strobes last one cycle
			send <= 1'b0;
			rxPayloadValid <= 1'b0;
			case (state)
				usbPkg::txnIdle:
					if (pkt.outToken)
						state <= usbPkg::txnAwait;
				usbPkg::txnAwait:
					if (dataSeen) begin
						state <= usbPkg::txnSend;
						send <= 1'b1;
						sendPid <= pkt.dataGood ? usbPkg::pidAck : usbPkg::pidNak;
						rxPayloadValid <= pkt.dataGood;
					end
				usbPkg::txnSend:
					// Packet events ignored until the handshake is out
					if (done)
						state <= (sendPid == usbPkg::pidNak) ? usbPkg::txnAwait :
							usbPkg::txnIdle;
				default:
					state <= usbPkg::txnIdle;
			endcase
		end
	end

	// Payload captured with the ACK decision
	always_ff @(posedge clk) begin
		if (dataSeen && pkt.dataGood)
			rxPayload <= pkt.payload;
	end

endmodule

/* run.sh */
#!/bin/sh
# Builds the USB OUT device testbench with Verilator and runs it.
# The log decides the result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module usbOutDeviceTb \
	-f usbOutDevice.f \
	--Mdir obj_dir -o usbOutDeviceSim

obj_dir/usbOutDeviceSim | tee sim.log

if grep -qx "all tests passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* sim/usbOutDeviceTb.sv */
/* Testbench for the USB OUT device. It plays the host on dpIn and dmIn,
   then decodes the handshake and checks the payload port. */

module usbOutDeviceTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [usbPkg::addrBits-1:0] devAddr = 7'h05;
	localparam logic [31:0] lcgSeed = 32'h5475_4ed6;
	// Cycles to wait for lineDrive
	localparam int responseTimeout = 40;

	logic clk;
	logic rst_L;
	logic dpIn;
	logic dmIn;
	logic dpOut;
	logic dmOut;
	logic lineDrive;
	logic [usbPkg::payloadBits-1:0] rxPayload;
	logic rxPayloadValid;

	// Host side state
	logic hostJ;
	logic fieldBits[$];
	logic [31:0] lcgState;
	int errorCount;
	int testsRun;
	int testsWithErrors;

	usbOutDevice #(.deviceAddr(devAddr)) dut0 (
		.clk(clk),
		.rst_L(rst_L),
		.dpIn(dpIn),
		.dmIn(dmIn),
		.dpOut(dpOut),
		.dmOut(dmOut),
		.lineDrive(lineDrive),
		.rxPayload(rxPayload),
		.rxPayloadValid(rxPayloadValid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//********************************************************************
	// Compare tasks
	//********************************************************************
	task automatic checkPid(input string name, input logic [usbPkg::pidBits-1:0] got,
		input logic [usbPkg::pidBits-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkPayload(input string name,
		input logic [usbPkg::payloadBits-1:0] got,
		input logic [usbPkg::payloadBits-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
			errorCount++;
		end
	endtask

	task automatic reportProblem(input string msg);
		$display("Error at %0t: %s", $time, msg);
		errorCount++;
	endtask

	//********************************************************************
	// Reference models
	//********************************************************************
	// Numerical Recipes constants
	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [63:0] randomWord();
		logic [31:0] hi;
		lcgState = lcgNext(lcgState);
		hi = lcgState;
		lcgState = lcgNext(lcgState);
		return {hi, lcgState};
	endfunction

	// Data taken LSB first, result complemented and ready to send MSB first
	function automatic logic [15:0] crcOf(input logic [63:0] data, input int count,
		input int width, input logic [15:0] poly);
		logic [15:0] mask;
		logic [15:0] crc;
		logic fb;
		mask = 16'((32'h1 << width) - 1);
		crc = mask;
		for (int i = 0; i < count; i++) begin
			fb = crc[width-1] ^ data[i];
			crc = ((crc << 1) ^ (fb ? poly : 16'h0)) & mask;
		end
		return ~crc & mask;
	endfunction

	//********************************************************************
	// Host bus-functional tasks
	//********************************************************************
	task automatic driveState(input logic dp, input logic dm);
		@(posedge clk);
		#2;
		dpIn = dp;
		dmIn = dm;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) driveState(1'b1, 1'b0);
	endtask

	// NRZI, a zero toggles the line
	task automatic sendNrz(input logic b);
		if (!b)
			hostJ = ~hostJ;
		driveState(hostJ, ~hostJ);
	endtask

	// SYNC, PID and the queued field bits with stuffing, then EOP
	task automatic sendPacket(input logic [usbPkg::pidBits-1:0] pid);
		int ones;
		hostJ = 1'b1;
		for (int i = 0; i < usbPkg::syncBits; i++)
			sendNrz(i == usbPkg::syncBits - 1);
		// PID goes in front, MSB first
		for (int i = 0; i < usbPkg::pidBits; i++)
			fieldBits.push_front(pid[i]);
		ones = 0;
		foreach (fieldBits[i]) begin
			sendNrz(fieldBits[i]);
			ones = fieldBits[i] ? ones + 1 : 0;
			if (ones == usbPkg::stuffRun) begin
				sendNrz(1'b0);
				ones = 0;
			end
		end
		driveState(1'b0, 1'b0);
		driveState(1'b0, 1'b0);
		driveState(1'b1, 1'b0);
		hostJ = 1'b1;
	endtask

	task automatic sendOut(input logic [usbPkg::addrBits-1:0] addr,
		input logic [usbPkg::endpBits-1:0] endp,
		input logic [usbPkg::crc5Bits-1:0] crcFlip);
		logic [63:0] tokenData;
		logic [15:0] crc;
		fieldBits.delete();
		tokenData = 64'({endp, addr});
		crc = crcOf(tokenData, usbPkg::addrBits + usbPkg::endpBits,
			usbPkg::crc5Bits, 16'(usbPkg::crc5Poly));
		crc[usbPkg::crc5Bits-1:0] = crc[usbPkg::crc5Bits-1:0] ^ crcFlip;
		for (int i = 0; i < usbPkg::addrBits + usbPkg::endpBits; i++)
			fieldBits.push_back(tokenData[i]);
		for (int i = usbPkg::crc5Bits - 1; i >= 0; i--)
			fieldBits.push_back(crc[i]);
		sendPacket(usbPkg::pidOut);
	endtask

	// CRC16 computed before flipMask corrupts the payload
	task automatic sendData(input logic [usbPkg::payloadBits-1:0] word,
		input logic [usbPkg::payloadBits-1:0] flipMask);
		logic [usbPkg::payloadBits-1:0] sent;
		logic [15:0] crc;
		fieldBits.delete();
		crc = crcOf(word, usbPkg::payloadBits, usbPkg::crc16Bits, usbPkg::crc16Poly);
		sent = word ^ flipMask;
		for (int i = 0; i < usbPkg::payloadBits; i++)
			fieldBits.push_back(sent[i]);
		for (int i = usbPkg::crc16Bits - 1; i >= 0; i--)
			fieldBits.push_back(crc[i]);
		sendPacket(usbPkg::pidData);
	endtask

	//********************************************************************
	// Response monitor
	//********************************************************************
	// Outputs sampled at the falling edge, mid cycle
	task automatic readHandshake(output logic seen, output logic [usbPkg::pidBits-1:0] pid,
		output logic firstStrobe, output logic extraStrobe,
		output logic [usbPkg::payloadBits-1:0] word);
		int waited;
		logic prevJ;
		logic [usbPkg::syncBits-1:0] syncGot;
		seen = 1'b0;
		pid = '0;
		firstStrobe = 1'b0;
		extraStrobe = 1'b0;
		word = '0;
		syncGot = '0;
		prevJ = 1'b1;
		waited = 0;
		while (!seen && waited < responseTimeout) begin
			@(negedge clk);
			if (lineDrive)
				seen = 1'b1;
			else begin
				extraStrobe = extraStrobe | rxPayloadValid;
				waited++;
			end
		end
		if (seen) begin
			firstStrobe = rxPayloadValid;
			word = rxPayload;
			for (int i = 0; i < usbPkg::handshakeBits; i++) begin
				if (i > 0) begin
					@(negedge clk);
					extraStrobe = extraStrobe | rxPayloadValid;
				end
				checkBit("lineDrive", lineDrive, 1'b1);
				if (i < usbPkg::syncBits + usbPkg::pidBits) begin
					if (dpOut == dmOut)
						reportProblem($sformatf("handshake bit %0d is neither J nor K", i));
					// Same state as before decodes as 1
					if (i < usbPkg::syncBits)
						syncGot[usbPkg::syncBits-1-i] = (dpOut == prevJ);
					else
						pid[usbPkg::syncBits+usbPkg::pidBits-1-i] = (dpOut == prevJ);
					prevJ = dpOut;
				end
				else if (i < usbPkg::handshakeBits - 1) begin
					if ({dpOut, dmOut} != 2'b00)
						reportProblem("handshake EOP is missing an SE0 state");
				end
				else if ({dpOut, dmOut} != 2'b10)
					reportProblem("handshake EOP does not end in J");
			end
			// KJKJKJKK from idle J
			checkPid("handshake SYNC", syncGot, 8'b0000_0001);
			@(negedge clk);
			checkBit("lineDrive after EOP", lineDrive, 1'b0);
		end
	endtask

	task automatic expectAck(input logic [usbPkg::payloadBits-1:0] exp);
		logic seen, first, extra;
		logic [usbPkg::pidBits-1:0] pid;
		logic [usbPkg::payloadBits-1:0] word;
		readHandshake(seen, pid, first, extra, word);
		if (!seen)
			reportProblem("no ACK handshake appeared before the timeout");
		else begin
			checkPid("handshake PID", pid, usbPkg::pidAck);
			checkBit("rxPayloadValid", first, 1'b1);
			checkPayload("rxPayload", word, exp);
		end
		checkBit("rxPayloadValid outside ACK start", extra, 1'b0);
	endtask

	task automatic expectNak();
		logic seen, first, extra;
		logic [usbPkg::pidBits-1:0] pid;
		logic [usbPkg::payloadBits-1:0] word;
		readHandshake(seen, pid, first, extra, word);
		if (!seen)
			reportProblem("no NAK handshake appeared before the timeout");
		else
			checkPid("handshake PID", pid, usbPkg::pidNak);
		checkBit("rxPayloadValid", first | extra, 1'b0);
	endtask

	task automatic expectSilence();
		logic seen, first, extra;
		logic [usbPkg::pidBits-1:0] pid;
		logic [usbPkg::payloadBits-1:0] word;
		readHandshake(seen, pid, first, extra, word);
		if (seen)
			reportProblem("device answered a transfer it should ignore");
		checkBit("rxPayloadValid", first | extra, 1'b0);
	endtask

	task automatic finishTest(input string name, input int startErrors);
		testsRun++;
		if (errorCount != startErrors)
			testsWithErrors++;
		$display("[%0t] %s: %0d errors", $time, name, errorCount - startErrors);
	endtask

	//********************************************************************
	// Directed tests
	//********************************************************************
	task automatic testAfterReset();
		int start;
		start = errorCount;
		repeat (30) begin
			@(negedge clk);
			checkBit("lineDrive", lineDrive, 1'b0);
			checkBit("rxPayloadValid", rxPayloadValid, 1'b0);
		end
		finishTest("idle after reset", start);
	endtask

	task automatic testGoodTransfers();
		int start;
		logic [usbPkg::payloadBits-1:0] word;
		start = errorCount;
		repeat (4) begin
			word = randomWord();
			sendOut(devAddr, usbPkg::outEndpoint, '0);
			idle(3);
			sendData(word, '0);
			expectAck(word);
			idle(2);
		end
		finishTest("OUT and DATA with random payloads", start);
	endtask

	task automatic testStuffing();
		int start;
		logic [usbPkg::payloadBits-1:0] words[3];
		start = errorCount;
		// Runs that join the PID tail and run into the CRC
		words[0] = 64'hffff_ffff_ffff_ffff;
		words[1] = 64'hf800_0000_0000_000f;
		words[2] = 64'hffc0_0000_0000_07ff;
		foreach (words[i]) begin
			sendOut(devAddr, usbPkg::outEndpoint, '0);
			idle(3);
			sendData(words[i], '0);
			expectAck(words[i]);
			idle(2);
		end
		finishTest("payloads with stuffed bits", start);
	endtask

	task automatic testCrcError();
		int start;
		logic [usbPkg::payloadBits-1:0] word;
		start = errorCount;
		word = randomWord();
		sendOut(devAddr, usbPkg::outEndpoint, '0);
		idle(3);
		sendData(word, 64'h1 << 17);
		expectNak();
		// Device still waits for DATA after a NAK
		idle(3);
		sendData(word, '0);
		expectAck(word);
		idle(2);
		finishTest("DATA with bad CRC16, then resent", start);
	endtask

	task automatic testRejectedTokens();
		int start;
		logic [usbPkg::payloadBits-1:0] word;
		start = errorCount;
		word = randomWord();
		sendOut(devAddr + 7'd1, usbPkg::outEndpoint, '0);
		idle(3);
		sendData(word, '0);
		expectSilence();
		sendOut(devAddr, 4'd2, '0);
		idle(3);
		sendData(word, '0);
		expectSilence();
		sendOut(devAddr, usbPkg::outEndpoint, 5'b00100);
		idle(3);
		sendData(word, '0);
		expectSilence();
		finishTest("OUT to other address, endpoint or bad CRC5", start);
	endtask

	//********************************************************************
	// Main sequence
	//********************************************************************
	initial begin
		rst_L = 1'b0;
		dpIn = 1'b1;
		dmIn = 1'b0;
		hostJ = 1'b1;
		lcgState = lcgSeed;
		errorCount = 0;
		testsRun = 0;
		testsWithErrors = 0;
		repeat (4) @(posedge clk);
		#2;
		rst_L = 1'b1;

		testAfterReset();
		testGoodTransfers();
		testStuffing();
		testCrcError();
		testRejectedTokens();

		$display("%0d tests run, %0d with errors, %0d failed checks",
			testsRun, testsWithErrors, errorCount);
		if (errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* usbOutDevice.f */
logic/usbPkg.sv
logic/usbIfs.sv
logic/usbCrcCheck.sv
logic/usbLineRx.sv
logic/usbPacketRx.sv
logic/usbTransaction.sv
logic/usbHandshakeTx.sv
logic/usbOutDevice.sv
sim/usbOutDeviceTb.sv
